/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/id_ctrl.sv
      - hw/inst_decoder.sv
      - hw/regfile.sv
      - hw/branch_unit.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/id_stage_assert.sv
      - verif/id_stage_tb.sv

/* hw/branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  br_kind_t   br_kind,
    input  word_t      rs_value,
    input  word_t      rt_value,
    input  imm_t       imm,
    input  jidx_t      jidx,
    input  word_t      pc,
    input  logic       valid,
    output br_bundle_t br
);

    word_t slot_pc;
    word_t br_offset;
    logic  rs_eq_rt;
    logic  rs_eq_zero;
    logic  rs_neg;
    logic  cond_br;
    logic  cond_met;

    // targets are relative to the delay slot
    assign slot_pc   = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};

    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_eq_zero = (rs_value == '0);
    assign rs_neg     = rs_value[31];

    assign cond_br = br_kind.beq | br_kind.bne | br_kind.bgez
                   | br_kind.bgtz | br_kind.blez | br_kind.bltz;

    assign cond_met = (br_kind.beq  &  rs_eq_rt)
                    | (br_kind.bne  & ~rs_eq_rt)
                    | (br_kind.bgez & ~rs_neg)
                    | (br_kind.bgtz & ~rs_neg & ~rs_eq_zero)
                    | (br_kind.blez & (rs_neg | rs_eq_zero))
                    | (br_kind.bltz &  rs_neg);

    always_comb begin
        br.taken = valid & (cond_met | br_kind.jimm | br_kind.jreg);
        if (cond_br) begin
            br.target = slot_pc + br_offset;
        end else if (br_kind.jreg) begin
            br.target = rs_value;
        end else begin
            // region of the delay slot
            br.target = {slot_pc[31:28], jidx, 2'b00};
        end
    end

endmodule

`default_nettype wire

/* hw/id_cfg.svh */
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// data path width
`define ID_DATA_W   32

// general purpose register file
`define ID_REG_N    32
`define ID_RADDR_W  5

// exception codes raised in decode
`define ID_EXC_ADEL 5'd4
`define ID_EXC_SYS  5'd8
`define ID_EXC_BP   5'd9

`endif

/* hw/id_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module id_ctrl
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fs_valid,
    input  fs_bundle_t fs_bundle,
    input  logic       es_allowin,
    input  logic       stall,
    input  logic       flush,
    output logic       ds_allowin,
    output logic       ds_valid,
    output logic       ds_valid_out,
    output fs_bundle_t held
);

    logic ready_go;
    logic accept;

    // hazard unit holds the item while stall is high
    assign ready_go = ~stall;

    // empty, or the held item leaves this cycle
    assign ds_allowin   = ~ds_valid | (ready_go & es_allowin);
    assign ds_valid_out = ds_valid & ready_go;

    // a flush edge takes nothing in
    assign accept = fs_valid & ds_allowin & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // pc, instruction and fetch error of the item in decode
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= fs_bundle;
        end
    end

endmodule

`default_nettype wire

/* hw/id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fs_valid,
    input  fs_bundle_t fs_bundle,
    input  logic       es_allowin,
    input  logic       stall,
    input  logic       flush,
    input  wb_bundle_t wb,
    output logic       ds_allowin,
    output logic       ds_valid_out,
    output ds_bundle_t ds_bundle,
    output br_bundle_t br
);

    // occupancy, independent of stall
    logic       ds_valid;
    fs_bundle_t held;
    reg_addr_t  rs;
    reg_addr_t  rt;
    ds_ctrl_t   ctrl;
    br_kind_t   br_kind;
    word_t      rs_value;
    word_t      rt_value;

    id_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fs_valid     (fs_valid),
        .fs_bundle    (fs_bundle),
        .es_allowin   (es_allowin),
        .stall        (stall),
        .flush        (flush),
        .ds_allowin   (ds_allowin),
        .ds_valid     (ds_valid),
        .ds_valid_out (ds_valid_out),
        .held         (held)
    );

    inst_decoder dec_i (
        .inst      (held.inst),
        .pc        (held.pc),
        .fetch_err (held.fetch_err),
        .rs        (rs),
        .rt        (rt),
        .ctrl      (ctrl),
        .br_kind   (br_kind)
    );

    regfile rf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs),
        .raddr2 (rt),
        .wb     (wb),
        .rdata1 (rs_value),
        .rdata2 (rt_value)
    );

    // operands may be stale under a hazard stall, so resolve only when leaving
    branch_unit br_i (
        .br_kind  (br_kind),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .imm      (ctrl.imm),
        .jidx     (held.inst[25:0]),
        .pc       (held.pc),
        .valid    (ds_valid_out),
        .br       (br)
    );

    assign ds_bundle = '{
        ctrl:     ctrl,
        rs_value: rs_value,
        rt_value: rt_value,
        pc:       held.pc
    };

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "id_cfg.svh"

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t     inst,
    input  word_t     pc,
    input  logic      fetch_err,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output ds_ctrl_t  ctrl,
    output br_kind_t  br_kind
);

    opcode_t   op;
    reg_addr_t rd;
    shamt_t    sa;
    funct_t    func;
    logic      special;
    logic      r_alu;
    logic      adel;

    logic inst_add, inst_addu, inst_sub, inst_subu;
    logic inst_slt, inst_sltu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_lh, inst_lhu, inst_lb, inst_lbu;
    logic inst_sw, inst_sh, inst_sb;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr;
    logic inst_syscall, inst_break, inst_nop;
    logic is_load, is_store, link, dst_is_rt;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    assign special = (op == OP_SPECIAL);
    // register ALU forms require a zero shift field
    assign r_alu   = special & (sa == '0);

    assign inst_add  = r_alu & (func == FN_ADD);
    assign inst_addu = r_alu & (func == FN_ADDU);
    assign inst_sub  = r_alu & (func == FN_SUB);
    assign inst_subu = r_alu & (func == FN_SUBU);
    assign inst_slt  = r_alu & (func == FN_SLT);
    assign inst_sltu = r_alu & (func == FN_SLTU);
    assign inst_and  = r_alu & (func == FN_AND);
    assign inst_or   = r_alu & (func == FN_OR);
    assign inst_xor  = r_alu & (func == FN_XOR);
    assign inst_nor  = r_alu & (func == FN_NOR);
    assign inst_sllv = r_alu & (func == FN_SLLV);
    assign inst_srlv = r_alu & (func == FN_SRLV);
    assign inst_srav = r_alu & (func == FN_SRAV);

    // immediate shifts, rs must be zero
    assign inst_sll = special & (rs == '0) & (func == FN_SLL);
    assign inst_srl = special & (rs == '0) & (func == FN_SRL);
    assign inst_sra = special & (rs == '0) & (func == FN_SRA);

    assign inst_addi  = (op == OP_ADDI);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) & (rs == '0);

    assign inst_lw  = (op == OP_LW);
    assign inst_lh  = (op == OP_LH);
    assign inst_lhu = (op == OP_LHU);
    assign inst_lb  = (op == OP_LB);
    assign inst_lbu = (op == OP_LBU);
    assign inst_sw  = (op == OP_SW);
    assign inst_sh  = (op == OP_SH);
    assign inst_sb  = (op == OP_SB);

    assign inst_beq    = (op == OP_BEQ);
    assign inst_bne    = (op == OP_BNE);
    assign inst_bgtz   = (op == OP_BGTZ) & (rt == '0);
    assign inst_blez   = (op == OP_BLEZ) & (rt == '0);
    assign inst_bgez   = (op == OP_REGIMM) & (rt == RT_BGEZ);
    assign inst_bltz   = (op == OP_REGIMM) & (rt == RT_BLTZ);
    assign inst_bgezal = (op == OP_REGIMM) & (rt == RT_BGEZAL);
    assign inst_bltzal = (op == OP_REGIMM) & (rt == RT_BLTZAL);
    assign inst_j      = (op == OP_J);
    assign inst_jal    = (op == OP_JAL);
    assign inst_jr     = special & (func == FN_JR) & (rt == '0) & (rd == '0) & (sa == '0);
    assign inst_jalr   = special & (func == FN_JALR) & (rt == '0) & (sa == '0);

    assign inst_syscall = special & (func == FN_SYSCALL);
    assign inst_break   = special & (func == FN_BREAK);
    assign inst_nop     = (inst == '0);

    assign is_load   = inst_lw | inst_lh | inst_lhu | inst_lb | inst_lbu;
    assign is_store  = inst_sw | inst_sh | inst_sb;
    // link forms write pc + 8
    assign link      = inst_jal | inst_jalr | inst_bgezal | inst_bltzal;
    assign dst_is_rt = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_andi
                     | inst_ori | inst_xori | inst_lui | is_load;

    // misaligned pc is an address error as well
    assign adel = fetch_err | (pc[1:0] != 2'b00);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_add | inst_addu | inst_addi | inst_addiu
                              | is_load | is_store | link;
        ctrl.alu_op[ALU_SUB]  = inst_sub | inst_subu;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll | inst_sllv;
        ctrl.alu_op[ALU_SRL]  = inst_srl | inst_srlv;
        ctrl.alu_op[ALU_SRA]  = inst_sra | inst_srav;
        ctrl.alu_op[ALU_LUI]  = inst_lui;

        ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc   = link;
        ctrl.src2_is_simm = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_lui
                          | is_load | is_store;
        ctrl.src2_is_uimm = inst_andi | inst_ori | inst_xori;
        ctrl.src2_is_8    = link;

        ctrl.ld_w    = inst_lw;
        ctrl.ld_h    = inst_lh | inst_lhu;
        ctrl.ld_b    = inst_lb | inst_lbu;
        ctrl.ld_sign = inst_lh | inst_lb;
        ctrl.st_w    = inst_sw;
        ctrl.st_h    = inst_sh;
        ctrl.st_b    = inst_sb;

        ctrl.gr_we = ~(is_store | inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez
                     | inst_bltz | inst_j | inst_jr | inst_syscall | inst_break | inst_nop);

        if (inst_jal | inst_bgezal | inst_bltzal) begin
            ctrl.dest = 5'd31;
        end else if (dst_is_rt) begin
            ctrl.dest = rt;
        end else begin
            ctrl.dest = rd;
        end
        ctrl.imm       = inst[15:0];
        ctrl.signed_op = ~(inst_addu | inst_subu | inst_addiu);

        // fetch error wins over break, break over syscall
        ctrl.exc = adel | inst_break | inst_syscall;
        if (adel) begin
            ctrl.excode = `ID_EXC_ADEL;
        end else if (inst_break) begin
            ctrl.excode = `ID_EXC_BP;
        end else if (inst_syscall) begin
            ctrl.excode = `ID_EXC_SYS;
        end
    end

    always_comb begin
        br_kind.beq  = inst_beq;
        br_kind.bne  = inst_bne;
        br_kind.bgez = inst_bgez | inst_bgezal;
        br_kind.bgtz = inst_bgtz;
        br_kind.blez = inst_blez;
        br_kind.bltz = inst_bltz | inst_bltzal;
        br_kind.jimm = inst_j | inst_jal;
        br_kind.jreg = inst_jr | inst_jalr;
    end

endmodule

`default_nettype wire

/* hw/isa_pkg.sv */
`default_nettype none
`include "id_cfg.svh"

package isa_pkg;

    typedef logic [`ID_DATA_W-1:0]  word_t;
    typedef logic [`ID_RADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]             opcode_t;
    typedef logic [5:0]             funct_t;
    typedef logic [4:0]             shamt_t;
    typedef logic [15:0]            imm_t;
    typedef logic [25:0]            jidx_t;
    typedef logic [4:0]             excode_t;

    // one-hot ALU operation
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // branch class, at most one bit set
    typedef struct packed {
        logic beq;
        logic bne;
        // bgez and bgezal
        logic bgez;
        logic bgtz;
        logic blez;
        // bltz and bltzal
        logic bltz;
        // j and jal
        logic jimm;
        // jr and jalr
        logic jreg;
    } br_kind_t;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2b;

    // function field of OP_SPECIAL
    localparam funct_t FN_SLL     = 6'h00;
    localparam funct_t FN_SRL     = 6'h02;
    localparam funct_t FN_SRA     = 6'h03;
    localparam funct_t FN_SLLV    = 6'h04;
    localparam funct_t FN_SRLV    = 6'h06;
    localparam funct_t FN_SRAV    = 6'h07;
    localparam funct_t FN_JR      = 6'h08;
    localparam funct_t FN_JALR    = 6'h09;
    localparam funct_t FN_SYSCALL = 6'h0c;
    localparam funct_t FN_BREAK   = 6'h0d;
    localparam funct_t FN_ADD     = 6'h20;
    localparam funct_t FN_ADDU    = 6'h21;
    localparam funct_t FN_SUB     = 6'h22;
    localparam funct_t FN_SUBU    = 6'h23;
    localparam funct_t FN_AND     = 6'h24;
    localparam funct_t FN_OR      = 6'h25;
    localparam funct_t FN_XOR     = 6'h26;
    localparam funct_t FN_NOR     = 6'h27;
    localparam funct_t FN_SLT     = 6'h2a;
    localparam funct_t FN_SLTU    = 6'h2b;

    // rt field of OP_REGIMM
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

endpackage

`default_nettype wire

/* hw/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  fetch_err;
    } fs_bundle_t;

    // decoder result, everything except the operands and pc
    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_simm;
        logic      src2_is_uimm;
        logic      src2_is_8;
        logic      ld_w;
        logic      ld_h;
        logic      ld_b;
        logic      ld_sign;
        logic      st_w;
        logic      st_h;
        logic      st_b;
        logic      gr_we;
        reg_addr_t dest;
        imm_t      imm;
        logic      exc;
        excode_t   excode;
        logic      signed_op;
    } ds_ctrl_t;

    // decode to execute
    typedef struct packed {
        ds_ctrl_t ctrl;
        word_t    rs_value;
        word_t    rt_value;
        word_t    pc;
    } ds_bundle_t;

    // decode to fetch
    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bundle_t;

    // writeback to register file
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_bundle_t;

endpackage

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "id_cfg.svh"

module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  reg_addr_t  raddr1,
    input  reg_addr_t  raddr2,
    input  wb_bundle_t wb,
    output word_t      rdata1,
    output word_t      rdata2
);

    word_t rf [`ID_REG_N];

    // r0 is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ID_REG_N; i++) begin
                rf[i] <= '0;
            end
        end else if (wb.we && (wb.waddr != '0)) begin
            rf[wb.waddr] <= wb.wdata;
        end
    end

    // reads see the array before this edge's write
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* id_stage.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/id_ctrl.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/branch_unit.sv
hw/id_stage.sv
verif/id_stage_assert.sv
verif/id_stage_tb.sv

/* verif/id_stage_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage_assert
    import pipe_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       flush,
    input wire logic       es_allowin,
    input wire logic       ds_valid,
    input wire logic       ds_valid_out,
    input wire ds_bundle_t ds_bundle,
    input wire br_bundle_t br
);

    // number of failed assertions
    int err_cnt = 0;

    // stage comes out of reset empty
    reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !ds_valid_out && !br.taken)
        else begin
            $error("stage not empty after reset");
            err_cnt++;
        end

    // held item keeps its bundle until it leaves
    hold_bundle: assert property (@(posedge clk) disable iff (!rst_n)
        (ds_valid && !(ds_valid_out && es_allowin) && !flush) |=> ds_valid && $stable(ds_bundle))
        else begin
            $error("held bundle changed or item lost");
            err_cnt++;
        end

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !ds_valid_out)
        else begin
            $error("valid still high after flush");
            err_cnt++;
        end

    taken_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        br.taken |-> ds_valid_out)
        else begin
            $error("branch taken without a valid item");
            err_cnt++;
        end

endmodule

bind id_stage id_stage_assert assert_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .es_allowin   (es_allowin),
    .ds_valid     (ds_valid),
    .ds_valid_out (ds_valid_out),
    .ds_bundle    (ds_bundle),
    .br           (br)
);

`default_nettype wire

/* verif/id_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "id_cfg.svh"

module id_stage_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int ROUNDS = 6;
    localparam int N_KINDS = 46;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       fs_valid;
    fs_bundle_t fs_bundle;
    logic       es_allowin;
    logic       stall;
    logic       flush;
    wb_bundle_t wb;
    logic       ds_allowin;
    logic       ds_valid_out;
    ds_bundle_t ds_bundle;
    br_bundle_t br;
    logic       leaving;

    logic [31:0] lfsr = 32'd9771;
    word_t       shadow [32];
    ds_bundle_t  exp_b [1024];
    logic        exp_tk [1024];
    word_t       exp_tg [1024];
    logic [9:0]  wr_ptr;
    logic [9:0]  rd_ptr;
    ds_bundle_t  pend_b;
    logic        pend_tk;
    word_t       pend_tg;
    logic        acc_n;
    logic        lv_n;
    logic        drop_n;
    bit          bp_en;
    int          cycles = 0;
    string       test_name;

    always #2 clk = ~clk;

    id_stage dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fs_valid     (fs_valid),
        .fs_bundle    (fs_bundle),
        .es_allowin   (es_allowin),
        .stall        (stall),
        .flush        (flush),
        .wb           (wb),
        .ds_allowin   (ds_allowin),
        .ds_valid_out (ds_valid_out),
        .ds_bundle    (ds_bundle),
        .br           (br)
    );

    assign leaving = ds_valid_out & es_allowin;

    task automatic mismatch(input string check, input logic [255:0] expv,
                            input logic [255:0] actv);
        $display("[FAIL] %s %s expected %0h actual %0h", test_name, check, expv, actv);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abort(input string why);
        $display("%s: %s", test_name, why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'hD000_0001 : 32'h0);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // inputs for the coming edge are stable at the falling edge
    always @(negedge clk) begin
        acc_n = rst_n & fs_valid & ds_allowin & ~flush;
        lv_n = ds_valid_out & es_allowin;
        drop_n = flush & ~lv_n & (wr_ptr != rd_ptr);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (acc_n) begin
                exp_b[wr_ptr] <= pend_b;
                exp_tk[wr_ptr] <= pend_tk;
                exp_tg[wr_ptr] <= pend_tg;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (lv_n || drop_n) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // bound protocol checker counts its failures
    always @(posedge clk) begin
        if (dut_i.assert_i.err_cnt != 0) begin
            abort("a protocol assertion in the bound checker failed");
        end
    end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (!ds_valid_out && !br.taken && ds_allowin))
        else mismatch("reset", 3'b001,
                      {$sampled(ds_valid_out), $sampled(br.taken), $sampled(ds_allowin)});

    leave_known: assert property (@(posedge clk) disable iff (!rst_n)
        leaving |-> wr_ptr != rd_ptr)
        else abort("an item left that was never accepted or was flushed");

    bundle_ok: assert property (@(posedge clk) disable iff (!rst_n)
        leaving |-> ds_bundle == exp_b[rd_ptr])
        else mismatch("ds_bundle", $sampled(exp_b[rd_ptr]), $sampled(ds_bundle));

    taken_ok: assert property (@(posedge clk) disable iff (!rst_n)
        leaving |-> br.taken == exp_tk[rd_ptr])
        else mismatch("br.taken", $sampled(exp_tk[rd_ptr]), $sampled(br.taken));

    target_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (leaving && exp_tk[rd_ptr]) |-> br.target == exp_tg[rd_ptr])
        else mismatch("br.target", $sampled(exp_tg[rd_ptr]), $sampled(br.target));

    task automatic tick();
        @(posedge clk);
        #0.5;
        if (bp_en) begin
            stall = (take_bits(2) == '0);
            es_allowin = (take_bits(2) != '0);
        end
    endtask

    // encodes kind k with random fields and works out the expected result
    task automatic make_item(input int k, input logic ferr, output fs_bundle_t fb,
                             output ds_bundle_t eb, output logic tk, output word_t tg);
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        shamt_t      sa;
        imm_t        imm;
        jidx_t       jidx;
        word_t       inst;
        word_t       pc;
        word_t       rv;
        word_t       tv;
        word_t       rw;
        logic [25:0] iw;
        ds_ctrl_t    e;
        int          idx;
        logic        lnk;
        logic        dst_31;
        rs = reg_addr_t'(take_bits(5));
        rt = reg_addr_t'(take_bits(5));
        rd = reg_addr_t'(take_bits(5));
        sa = shamt_t'(take_bits(5));
        imm = imm_t'(take_bits(16));
        jidx = jidx_t'(take_bits(26));
        pc = {30'(take_bits(30)), 2'b00};
        rw = {OP_SPECIAL, rs, rt, rd, 5'd0, 6'd0};
        iw = {rs, rt, imm};
        case (k)
            0: inst = rw | FN_ADD;
            1: inst = rw | FN_ADDU;
            2: inst = rw | FN_SUB;
            3: inst = rw | FN_SUBU;
            4: inst = rw | FN_SLT;
            5: inst = rw | FN_SLTU;
            6: inst = rw | FN_AND;
            7: inst = rw | FN_OR;
            8: inst = rw | FN_XOR;
            9: inst = rw | FN_NOR;
            10: inst = rw | FN_SLLV;
            11: inst = rw | FN_SRLV;
            12: inst = rw | FN_SRAV;
            13: inst = {OP_SPECIAL, 5'd0, rt, rd, sa, FN_SLL};
            14: inst = {OP_SPECIAL, 5'd0, rt, rd, sa, FN_SRL};
            15: inst = {OP_SPECIAL, 5'd0, rt, rd, sa, FN_SRA};
            16: inst = {OP_ADDI, iw};
            17: inst = {OP_ADDIU, iw};
            18: inst = {OP_SLTI, iw};
            19: inst = {OP_SLTIU, iw};
            20: inst = {OP_ANDI, iw};
            21: inst = {OP_ORI, iw};
            22: inst = {OP_XORI, iw};
            23: inst = {OP_LUI, 5'd0, rt, imm};
            24: inst = {OP_LW, iw};
            25: inst = {OP_LH, iw};
            26: inst = {OP_LHU, iw};
            27: inst = {OP_LB, iw};
            28: inst = {OP_LBU, iw};
            29: inst = {OP_SW, iw};
            30: inst = {OP_SH, iw};
            31: inst = {OP_SB, iw};
            32: inst = {OP_BEQ, iw};
            33: inst = {OP_BNE, iw};
            34: inst = {OP_REGIMM, rs, RT_BGEZ, imm};
            35: inst = {OP_BGTZ, rs, 5'd0, imm};
            36: inst = {OP_BLEZ, rs, 5'd0, imm};
            37: inst = {OP_REGIMM, rs, RT_BLTZ, imm};
            38: inst = {OP_REGIMM, rs, RT_BGEZAL, imm};
            39: inst = {OP_REGIMM, rs, RT_BLTZAL, imm};
            40: inst = {OP_J, jidx};
            41: inst = {OP_JAL, jidx};
            42: inst = {OP_SPECIAL, rs, 15'd0, FN_JR};
            43: inst = {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FN_JALR};
            44: inst = {OP_SPECIAL, rs, rt, rd, sa, FN_SYSCALL};
            default: inst = {OP_SPECIAL, rs, rt, rd, sa, FN_BREAK};
        endcase
        case (k)
            0, 1, 16, 17, 24, 25, 26, 27, 28, 29, 30, 31: idx = ALU_ADD;
            2, 3: idx = ALU_SUB;
            4, 18: idx = ALU_SLT;
            5, 19: idx = ALU_SLTU;
            6, 20: idx = ALU_AND;
            7, 21: idx = ALU_OR;
            8, 22: idx = ALU_XOR;
            9: idx = ALU_NOR;
            10, 13: idx = ALU_SLL;
            11, 14: idx = ALU_SRL;
            12, 15: idx = ALU_SRA;
            23: idx = ALU_LUI;
            default: idx = -1;
        endcase
        e = '0;
        if (idx >= 0) begin
            e.alu_op[idx] = 1'b1;
        end
        lnk = (k == 38) || (k == 39) || (k == 41) || (k == 43);
        dst_31 = (k == 38) || (k == 39) || (k == 41);
        // links add 8 to the pc
        if (lnk) begin
            e.alu_op[ALU_ADD] = 1'b1;
            e.src1_is_pc = 1'b1;
            e.src2_is_8 = 1'b1;
        end
        e.src1_is_sa = (k >= 13) && (k <= 15);
        e.src2_is_simm = ((k >= 16) && (k <= 19)) || ((k >= 23) && (k <= 31));
        e.src2_is_uimm = (k >= 20) && (k <= 22);
        e.ld_w = (k == 24);
        e.ld_h = (k == 25) || (k == 26);
        e.ld_b = (k == 27) || (k == 28);
        e.ld_sign = (k == 25) || (k == 27);
        e.st_w = (k == 29);
        e.st_h = (k == 30);
        e.st_b = (k == 31);
        e.gr_we = !(((k >= 29) && (k <= 37)) || (k == 40) || (k == 42) || (k >= 44)
                    || (inst == '0));
        if (dst_31) begin
            e.dest = 5'd31;
        end else if ((k >= 16) && (k <= 28)) begin
            e.dest = inst[20:16];
        end else begin
            e.dest = inst[15:11];
        end
        e.imm = inst[15:0];
        e.signed_op = !((k == 1) || (k == 3) || (k == 17));
        if (ferr) begin
            e.exc = 1'b1;
            e.excode = `ID_EXC_ADEL;
        end else if (k == 45) begin
            e.exc = 1'b1;
            e.excode = `ID_EXC_BP;
        end else if (k == 44) begin
            e.exc = 1'b1;
            e.excode = `ID_EXC_SYS;
        end
        rv = shadow[inst[25:21]];
        tv = shadow[inst[20:16]];
        case (k)
            32: tk = (rv == tv);
            33: tk = (rv != tv);
            34, 38: tk = !rv[31];
            35: tk = !rv[31] && (rv != '0);
            36: tk = rv[31] || (rv == '0);
            37, 39: tk = rv[31];
            40, 41, 42, 43: tk = 1'b1;
            default: tk = 1'b0;
        endcase
        if ((k >= 32) && (k <= 39)) begin
            tg = pc + 32'd4 + {{14{inst[15]}}, inst[15:0], 2'b00};
        end else if ((k == 40) || (k == 41)) begin
            tg = {pc[31:28] + (pc[27:0] > 28'hFFFFFFB ? 4'd1 : 4'd0), inst[25:0], 2'b00};
        end else begin
            tg = rv;
        end
        fb = '{pc: pc, inst: inst, fetch_err: ferr};
        eb = '{ctrl: e, rs_value: rv, rt_value: tv, pc: pc};
    endtask

    task automatic send_item(input int k, input logic ferr);
        fs_bundle_t fb;
        logic       got;
        make_item(k, ferr, fb, pend_b, pend_tk, pend_tg);
        fs_bundle = fb;
        fs_valid = 1'b1;
        do begin
            @(negedge clk);
            got = ds_allowin & ~flush;
            tick();
        end while (!got);
        fs_valid = 1'b0;
    endtask

    task automatic drain();
        fs_valid = 1'b0;
        if (!bp_en) begin
            stall = 1'b0;
            es_allowin = 1'b1;
        end
        while (rd_ptr != wr_ptr) begin
            tick();
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        wb = '{we: 1'b1, waddr: a, wdata: d};
        if (a != '0) begin
            shadow[a] = d;
        end
        tick();
        wb.we = 1'b0;
    endtask

    // item sits in decode under stall until flush drops it
    task automatic flush_held();
        fs_bundle_t fb;
        ds_bundle_t eb;
        logic       tk;
        word_t      tg;
        bp_en = 1'b0;
        stall = 1'b1;
        es_allowin = 1'b1;
        send_item(take_bits(5), 1'b0);
        make_item(take_bits(5), 1'b0, fb, eb, tk, tg);
        fs_bundle = fb;
        fs_valid = 1'b1;
        flush = 1'b1;
        tick();
        flush = 1'b0;
        fs_valid = 1'b0;
        stall = 1'b0;
        tick();
        tick();
    endtask

    initial begin
        rst_n = 1'b0;
        fs_valid = 1'b0;
        fs_bundle = '0;
        es_allowin = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        wb = '0;
        bp_en = 1'b0;
        pend_b = '0;
        pend_tk = 1'b0;
        pend_tg = '0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        tick();
        tick();

        test_name = "regfile";
        for (int a = 0; a < 32; a++) begin
            write_reg(reg_addr_t'(a), take_bits(32));
        end

        bp_en = 1'b1;
        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 0; k < N_KINDS; k++) begin
                test_name = (k < 32) ? "decode" : ((k < 44) ? "branch" : "exception");
                send_item(k, (take_bits(3) == '0) || ((r == 0) && (k >= 44)));
            end
            test_name = "regfile";
            drain();
            repeat (8) begin
                write_reg(reg_addr_t'(take_bits(5)), take_bits(32));
            end
        end

        test_name = "flush";
        repeat (3) begin
            flush_held();
        end
        drain();
        tick();

        if ((dut_i.assert_i.err_cnt == 0) && (rd_ptr == wr_ptr)) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("protocol assertion failed or items were left over");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
